// File: bench_params.svh
/*
 * widths and engine counts for the benchmark role
 * command fields, cycle counts, network keep lanes, statistics counters
 */
`ifndef BENCH_PARAMS_SVH
`define BENCH_PARAMS_SVH

// benchmark command fields
`define BENCH_ADDR_W 48   // base address and memory size
`define BENCH_WORD_W 32   // access count, chunk and stride length

// engine cycle counts
`define CYCLES_W 64

// tcp data path, 64-bit beats
`define NET_KEEP_W 8

// statistics
`define STAT_BYTES_W 48
`define STAT_CNT_W   32

// ddr benchmark engines behind the dest field
`define DDR_ENGINES 2
`define DDR_DEST_W  2

`endif

// File: bench_pkg.sv
/*
 * shared types for the benchmark role
 * command word, observed stream beat, tx status word
 */
`default_nettype none

`include "bench_params.svh"

package bench_pkg;

   // same bit order as the 193-bit command word, msb first
   typedef struct packed {
      logic                     is_write;
      logic [`BENCH_WORD_W-1:0] stride_len;
      logic [`BENCH_WORD_W-1:0] chunk_len;
      logic [`BENCH_WORD_W-1:0] num_accesses;
      logic [`BENCH_ADDR_W-1:0] mem_size;
      logic [`BENCH_ADDR_W-1:0] base_addr;
   } bench_params_t;

   // one beat as seen on a monitored data stream
   typedef struct packed {
      logic                   valid;
      logic                   ready;
      logic                   last;
      logic [`NET_KEEP_W-1:0] keep;   // byte lanes, lane 0 first
   } net_beat_t;

   // tx status word, only the error field is looked at
   typedef struct packed {
      logic [1:0]  error;   // zero means good
      logic [61:0] rest;
   } tx_status_t;

endpackage

`default_nettype wire

// File: bench_cmd_decoder.sv
/*
 * benchmark command decoder
 * accepts a command, latches its parameters and sends a one-cycle
 * start pulse to the engine picked by the destination field
 */
`timescale 1ns/100ps
`default_nettype none

`include "bench_params.svh"

module bench_cmd_decoder #(
   parameter int NUM_ENGINES = 1
) (
   input  wire                           user_clk,
   input  wire                           user_aresetn,

   input  wire                           cmd_valid,
   input  wire bench_pkg::bench_params_t cmd,
   input  wire [`DDR_DEST_W-1:0]         cmd_dest,
   output logic                          cmd_ready,

   output bench_pkg::bench_params_t      params,
   output logic [NUM_ENGINES-1:0]        start,
   output logic                          accepted
);

   logic [NUM_ENGINES-1:0] start_sel;

   assign accepted = cmd_valid & cmd_ready;

   // one-hot of the destination; out of range dest gives all zero
   always_comb begin
      for (int i = 0; i < NUM_ENGINES; i++) begin
         start_sel[i] = (cmd_dest == i);
      end
   end

   always_ff @(posedge user_clk) begin
      if (!user_aresetn) begin
         cmd_ready <= 1'b0;
         start     <= '0;
      end else begin
         cmd_ready <= 1'b1;   // no back-pressure once out of reset
         start     <= '0;     // single cycle pulse
         if (accepted) begin
            start <= start_sel;
         end
      end
   end

   // parameters stay put until the next command
   always_ff @(posedge user_clk) begin
      if (accepted) begin
         params <= cmd;
      end
   end

   a_start_onehot: assert property (
      @(posedge user_clk) disable iff (!user_aresetn)
      $onehot0(start)
   ) else $error("more than one engine started at once");

endmodule

`default_nettype wire

// File: bench_run_timer.sv
/*
 * benchmark run timer
 * run flag, busy cycle counter and capture of the engine's
 * reported execution cycles, highest engine index wins
 */
`timescale 1ns/100ps
`default_nettype none

`include "bench_params.svh"

module bench_run_timer #(
   parameter int NUM_ENGINES = 1
) (
   input  wire                                  user_clk,
   input  wire                                  user_aresetn,

   input  wire                                  accepted,
   input  wire [NUM_ENGINES-1:0]                done_valid,
   input  wire [NUM_ENGINES-1:0][`CYCLES_W-1:0] done_cycles,

   output logic                                 running,
   output logic [`CYCLES_W-1:0]                 busy_cycles,
   output logic [`CYCLES_W-1:0]                 exec_cycles
);

   logic                 done_any;
   logic [`CYCLES_W-1:0] done_sel;

   // later engines override earlier ones
   always_comb begin
      done_any = 1'b0;
      done_sel = '0;
      for (int i = 0; i < NUM_ENGINES; i++) begin
         if (done_valid[i]) begin
            done_any = 1'b1;
            done_sel = done_cycles[i];
         end
      end
   end

   always_ff @(posedge user_clk) begin
      if (!user_aresetn) begin
         running     <= 1'b0;
         busy_cycles <= '0;
         exec_cycles <= '0;
      end else begin
         if (running) begin
            busy_cycles <= busy_cycles + 1'b1;
         end
         if (accepted) begin
            running     <= 1'b1;
            busy_cycles <= '0;
            exec_cycles <= '0;
         end
         if (done_any) begin   // done beats a same-cycle accept
            running     <= 1'b0;
            exec_cycles <= done_sel;
         end
      end
   end

   a_run_after_accept: assert property (
      @(posedge user_clk) disable iff (!user_aresetn)
      (accepted && !done_any) |=> running
   ) else $error("run flag not set after an accepted command");

endmodule

`default_nettype wire

// File: stream_byte_counter.sv
/*
 * byte and packet totals for one observed data stream
 * only keep masks that are a run of ones from lane 0 add bytes
 */
`timescale 1ns/100ps
`default_nettype none

`include "bench_params.svh"

module stream_byte_counter (
   input  wire                       user_clk,
   input  wire                       user_aresetn,

   input  wire bench_pkg::net_beat_t beat,

   output logic [`STAT_BYTES_W-1:0]  bytes,
   output logic [`STAT_CNT_W-1:0]    packets
);

   localparam int KEEP_W  = `NET_KEEP_W;
   localparam int LANE_CW = $clog2(KEEP_W + 1);

   logic               beat_fire;
   logic [LANE_CW-1:0] keep_bytes;

   assign beat_fire = beat.valid & beat.ready;

   // 0x01 -> 1, 0x03 -> 2 ... 0xff -> 8, anything else 0
   always_comb begin
      keep_bytes = '0;
      for (int n = 1; n <= KEEP_W; n++) begin
         if (beat.keep == KEEP_W'((1 << n) - 1)) begin
            keep_bytes = LANE_CW'(n);
         end
      end
   end

   always_ff @(posedge user_clk) begin
      if (!user_aresetn) begin
         bytes   <= '0;
         packets <= '0;
      end else if (beat_fire) begin
         bytes <= bytes + `STAT_BYTES_W'(keep_bytes);
         if (beat.last) begin
            packets <= packets + 1'b1;
         end
      end
   end

   a_keep_known: assert property (
      @(posedge user_clk) disable iff (!user_aresetn)
      beat_fire |-> !$isunknown(beat.keep)
   ) else $error("counted beat carries an unknown keep mask");

endmodule

`default_nettype wire

// File: tx_session_stats.sv
/*
 * transmit session statistics
 * metadata handshakes, status handshakes and good status words
 */
`timescale 1ns/100ps
`default_nettype none

`include "bench_params.svh"

module tx_session_stats (
   input  wire                        user_clk,
   input  wire                        user_aresetn,

   input  wire                        meta_valid,
   input  wire                        meta_ready,
   input  wire                        status_valid,
   input  wire                        status_ready,
   input  wire bench_pkg::tx_status_t status,

   output logic [`STAT_CNT_W-1:0]     meta_count,
   output logic [`STAT_CNT_W-1:0]     status_count,
   output logic [`STAT_CNT_W-1:0]     status_good_count
);

   logic meta_fire;
   logic status_fire;
   logic status_good;

   assign meta_fire   = meta_valid & meta_ready;
   assign status_fire = status_valid & status_ready;
   assign status_good = (status.error == 2'b00);

   always_ff @(posedge user_clk) begin
      if (!user_aresetn) begin
         meta_count        <= '0;
         status_count      <= '0;
         status_good_count <= '0;
      end else begin
         if (meta_fire) begin
            meta_count <= meta_count + 1'b1;
         end
         if (status_fire) begin
            status_count <= status_count + 1'b1;
            if (status_good) begin
               status_good_count <= status_good_count + 1'b1;
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: benchmark_role.sv
/*
 * benchmark role, control and statistics core
 * dma and ddr command paths with run timers, tcp stream statistics
 */
`timescale 1ns/100ps
`default_nettype none

`include "bench_params.svh"

module benchmark_role (
   input  wire                                   user_clk,
   input  wire                                   user_aresetn,

   // dma benchmark command
   input  wire                                   dma_cmd_valid,
   input  wire bench_pkg::bench_params_t         dma_cmd,
   output logic                                  dma_cmd_ready,
   output logic                                  dma_start,
   output bench_pkg::bench_params_t              dma_params,

   // ddr benchmark command
   input  wire                                   ddr_cmd_valid,
   input  wire bench_pkg::bench_params_t         ddr_cmd,
   input  wire [`DDR_DEST_W-1:0]                 ddr_cmd_dest,
   output logic                                  ddr_cmd_ready,
   output logic [`DDR_ENGINES-1:0]               ddr_start,
   output bench_pkg::bench_params_t              ddr_params,

   // engine completion
   input  wire                                   dma_done_valid,
   input  wire [`CYCLES_W-1:0]                   dma_done_cycles,
   input  wire [`DDR_ENGINES-1:0]                ddr_done_valid,
   input  wire [`DDR_ENGINES-1:0][`CYCLES_W-1:0] ddr_done_cycles,

   output logic                                  dma_running,
   output logic [`CYCLES_W-1:0]                  dma_busy_cycles,
   output logic [`CYCLES_W-1:0]                  dma_exec_cycles,
   output logic                                  ddr_running,
   output logic [`CYCLES_W-1:0]                  ddr_busy_cycles,
   output logic [`CYCLES_W-1:0]                  ddr_exec_cycles,

   // monitored tcp streams
   input  wire bench_pkg::net_beat_t             rx_beat,
   input  wire bench_pkg::net_beat_t             tx_beat,
   input  wire                                   tx_meta_valid,
   input  wire                                   tx_meta_ready,
   input  wire                                   tx_status_valid,
   input  wire                                   tx_status_ready,
   input  wire bench_pkg::tx_status_t            tx_status,

   output logic [`STAT_BYTES_W-1:0]              rx_bytes,
   output logic [`STAT_BYTES_W-1:0]              tx_bytes,
   output logic [`STAT_CNT_W-1:0]                tx_packets,
   output logic [`STAT_CNT_W-1:0]                tx_meta_count,
   output logic [`STAT_CNT_W-1:0]                tx_status_count,
   output logic [`STAT_CNT_W-1:0]                tx_status_good_count
);

   logic dma_accepted;
   logic ddr_accepted;

   // dma path, single engine so dest is tied off
   bench_cmd_decoder #(.NUM_ENGINES(1)) u_dma_decoder (
      .user_clk     (user_clk),
      .user_aresetn (user_aresetn),
      .cmd_valid    (dma_cmd_valid),
      .cmd          (dma_cmd),
      .cmd_dest     ({`DDR_DEST_W{1'b0}}),
      .cmd_ready    (dma_cmd_ready),
      .params       (dma_params),
      .start        (dma_start),
      .accepted     (dma_accepted)
   );

   bench_run_timer #(.NUM_ENGINES(1)) u_dma_timer (
      .user_clk     (user_clk),
      .user_aresetn (user_aresetn),
      .accepted     (dma_accepted),
      .done_valid   (dma_done_valid),
      .done_cycles  (dma_done_cycles),
      .running      (dma_running),
      .busy_cycles  (dma_busy_cycles),
      .exec_cycles  (dma_exec_cycles)
   );

   // ddr path
   bench_cmd_decoder #(.NUM_ENGINES(`DDR_ENGINES)) u_ddr_decoder (
      .user_clk     (user_clk),
      .user_aresetn (user_aresetn),
      .cmd_valid    (ddr_cmd_valid),
      .cmd          (ddr_cmd),
      .cmd_dest     (ddr_cmd_dest),
      .cmd_ready    (ddr_cmd_ready),
      .params       (ddr_params),
      .start        (ddr_start),
      .accepted     (ddr_accepted)
   );

   bench_run_timer #(.NUM_ENGINES(`DDR_ENGINES)) u_ddr_timer (
      .user_clk     (user_clk),
      .user_aresetn (user_aresetn),
      .accepted     (ddr_accepted),
      .done_valid   (ddr_done_valid),
      .done_cycles  (ddr_done_cycles),
      .running      (ddr_running),
      .busy_cycles  (ddr_busy_cycles),
      .exec_cycles  (ddr_exec_cycles)
   );

   // consumed bytes, rx packet total not needed
   stream_byte_counter u_rx_counter (
      .user_clk     (user_clk),
      .user_aresetn (user_aresetn),
      .beat         (rx_beat),
      .bytes        (rx_bytes),
      .packets      ()
   );

   stream_byte_counter u_tx_counter (
      .user_clk     (user_clk),
      .user_aresetn (user_aresetn),
      .beat         (tx_beat),
      .bytes        (tx_bytes),
      .packets      (tx_packets)
   );

   tx_session_stats u_tx_stats (
      .user_clk          (user_clk),
      .user_aresetn      (user_aresetn),
      .meta_valid        (tx_meta_valid),
      .meta_ready        (tx_meta_ready),
      .status_valid      (tx_status_valid),
      .status_ready      (tx_status_ready),
      .status            (tx_status),
      .meta_count        (tx_meta_count),
      .status_count      (tx_status_count),
      .status_good_count (tx_status_good_count)
   );

endmodule

`default_nettype wire

// File: tb_benchmark_role.sv
/*
 * testbench for the benchmark role
 * clock and reset, xorshift stimulus, reference functions,
 * compare tasks, stream model with its checking process
 */
`timescale 1ns/100ps
`default_nettype none

`include "bench_params.svh"

module tb_benchmark_role;

   import bench_pkg::*;

   localparam int READY_TIMEOUT = 50;
   localparam int STREAM_BEATS  = 400;

   logic                                   user_clk;
   logic                                   user_aresetn;
   logic                                   dma_cmd_valid;
   logic                                   ddr_cmd_valid;
   logic                                   dma_cmd_ready;
   logic                                   ddr_cmd_ready;
   bench_params_t                          dma_cmd;
   bench_params_t                          ddr_cmd;
   bench_params_t                          dma_params;
   bench_params_t                          ddr_params;
   logic [`DDR_DEST_W-1:0]                 ddr_cmd_dest;
   logic                                   dma_start;
   logic [`DDR_ENGINES-1:0]                ddr_start;
   logic                                   dma_done_valid;
   logic [`CYCLES_W-1:0]                   dma_done_cycles;
   logic [`DDR_ENGINES-1:0]                ddr_done_valid;
   logic [`DDR_ENGINES-1:0][`CYCLES_W-1:0] ddr_done_cycles;
   logic                                   dma_running;
   logic                                   ddr_running;
   logic [`CYCLES_W-1:0]                   dma_busy_cycles;
   logic [`CYCLES_W-1:0]                   dma_exec_cycles;
   logic [`CYCLES_W-1:0]                   ddr_busy_cycles;
   logic [`CYCLES_W-1:0]                   ddr_exec_cycles;
   net_beat_t                              rx_beat;
   net_beat_t                              tx_beat;
   logic                                   tx_meta_valid;
   logic                                   tx_meta_ready;
   logic                                   tx_status_valid;
   logic                                   tx_status_ready;
   tx_status_t                             tx_status;
   logic [`STAT_BYTES_W-1:0]               rx_bytes;
   logic [`STAT_BYTES_W-1:0]               tx_bytes;
   logic [`STAT_BYTES_W-1:0]               exp_rx_bytes;
   logic [`STAT_BYTES_W-1:0]               exp_tx_bytes;
   logic [`STAT_CNT_W-1:0]                 tx_packets;
   logic [`STAT_CNT_W-1:0]                 tx_meta_count;
   logic [`STAT_CNT_W-1:0]                 tx_status_count;
   logic [`STAT_CNT_W-1:0]                 tx_status_good_count;
   logic [`STAT_CNT_W-1:0]                 exp_packets;
   logic [`STAT_CNT_W-1:0]                 exp_meta;
   logic [`STAT_CNT_W-1:0]                 exp_status;
   logic [`STAT_CNT_W-1:0]                 exp_good;
   logic [31:0]                            rng_state = 32'd21033;
   logic                                   stats_armed = 1'b0;
   int                                     param_errs = 0;
   int                                     cycle_errs = 0;
   int                                     flag_errs = 0;
   int                                     byte_errs = 0;
   int                                     count_errs = 0;
   int                                     timeouts = 0;

   benchmark_role u_benchmark_role (.*);

   initial begin
      user_clk = 1'b0;
      forever #10 user_clk = ~user_clk;   // 20 ns period
   end

   function automatic logic [31:0] next_random();
      rng_state ^= rng_state << 13;
      rng_state ^= rng_state >> 17;
      rng_state ^= rng_state << 5;
      return rng_state;
   endfunction

   function automatic bench_params_t random_params();
      bench_params_t p;
      p.is_write     = next_random() % 2;
      p.stride_len   = next_random();
      p.chunk_len    = next_random();
      p.num_accesses = next_random();
      p.mem_size     = `BENCH_ADDR_W'({next_random(), next_random()});
      p.base_addr    = `BENCH_ADDR_W'({next_random(), next_random()});
      return p;
   endfunction

   function automatic net_beat_t random_beat();
      net_beat_t   b;
      logic [31:0] r;
      r       = next_random();
      b.valid = r[0] | r[1];
      b.ready = r[2] | r[3];
      b.last  = r[4];
      // half clean runs from lane 0, half arbitrary masks
      b.keep  = r[5] ? ({`NET_KEEP_W{1'b1}} >> r[10:8]) : r[23:16];
      return b;
   endfunction

   // lanes set from lane 0 up, zero if a set lane follows a hole
   function automatic int unsigned keep_bytes_ref(logic [`NET_KEEP_W-1:0] keep);
      int unsigned run;
      bit          hole;
      run  = 0;
      hole = 1'b0;
      for (int i = 0; i < `NET_KEEP_W; i++) begin
         if (!keep[i])
            hole = 1'b1;
         else if (hole)
            return 0;
         else
            run++;
      end
      return run;
   endfunction

   function automatic logic [`DDR_ENGINES-1:0] start_vec_ref(int unsigned dest);
      return (dest < `DDR_ENGINES) ? `DDR_ENGINES'(1 << dest) : '0;
   endfunction

   function automatic bit status_good_ref(tx_status_t s);
      return s.error == 2'b00;
   endfunction

   task automatic check_params(string what, bench_params_t got, bench_params_t exp);
      if (got !== exp) begin
         param_errs++;
         $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_cycles(string what, logic [`CYCLES_W-1:0] got,
                               logic [`CYCLES_W-1:0] exp);
      if (got !== exp) begin
         cycle_errs++;
         $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic check_flags(string what, logic [7:0] got, logic [7:0] exp);
      if (got !== exp) begin
         flag_errs++;
         $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   task automatic check_bytes(string what, logic [`STAT_BYTES_W-1:0] got,
                              logic [`STAT_BYTES_W-1:0] exp);
      if (got !== exp) begin
         byte_errs++;
         $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic check_count(string what, logic [`STAT_CNT_W-1:0] got,
                              logic [`STAT_CNT_W-1:0] exp);
      if (got !== exp) begin
         count_errs++;
         $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic report_and_finish();
      int total;
      stats_armed = 1'b0;
      total = param_errs + cycle_errs + flag_errs + byte_errs + count_errs + timeouts;
      $display("errors: params %0d, cycles %0d, flags %0d, bytes %0d, counts %0d, timeouts %0d",
               param_errs, cycle_errs, flag_errs, byte_errs, count_errs, timeouts);
      if (total == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   endtask

   task automatic wait_cmd_ready(bit ddr_path, output bit ok);
      int polls;
      polls = 0;
      while ((ddr_path ? ddr_cmd_ready : dma_cmd_ready) !== 1'b1 && polls < READY_TIMEOUT) begin
         @(negedge user_clk);
         polls++;
      end
      ok = 1'b1;
      if ((ddr_path ? ddr_cmd_ready : dma_cmd_ready) !== 1'b1) begin
         timeouts++;
         ok = 1'b0;
         $display("timeout: command ready never went high on the %s path",
                  ddr_path ? "ddr" : "dma");
      end
   endtask

   // one command from acceptance to done, dest is ignored on the dma path
   task automatic run_command(bit ddr_path, int unsigned dest, bit both_done);
      bench_params_t                          p;
      logic [`DDR_ENGINES-1:0][`CYCLES_W-1:0] counts;
      logic [`DDR_ENGINES-1:0]                done_vec;
      int unsigned                            gap;
      int unsigned                            winner;
      string                                  path;
      bit                                     ok;
      p    = random_params();
      gap  = next_random() % 8;
      path = ddr_path ? "ddr" : "dma";
      for (int i = 0; i < `DDR_ENGINES; i++) begin
         counts[i] = {next_random(), next_random()};
      end
      done_vec = both_done ? '1 : start_vec_ref(dest);
      if (done_vec == '0)
         done_vec = 1;   // engine 0 closes a run that started nothing
      winner = 0;
      for (int i = 0; i < `DDR_ENGINES; i++) begin
         if (done_vec[i])
            winner = i;   // highest index wins
      end
      wait_cmd_ready(ddr_path, ok);
      if (!ok)
         return;
      if (ddr_path) begin
         ddr_cmd       = p;
         ddr_cmd_dest  = `DDR_DEST_W'(dest);
         ddr_cmd_valid = 1'b1;
      end else begin
         dma_cmd       = p;
         dma_cmd_valid = 1'b1;
      end
      @(negedge user_clk);   // acceptance edge is behind us
      dma_cmd_valid = 1'b0;
      ddr_cmd_valid = 1'b0;
      check_params({path, "_params"}, ddr_path ? ddr_params : dma_params, p);
      check_flags({path, "_start"}, ddr_path ? 8'(ddr_start) : 8'(dma_start),
                  ddr_path ? 8'(start_vec_ref(dest)) : 8'd1);
      check_flags({path, "_running"}, 8'(ddr_path ? ddr_running : dma_running), 8'd1);
      check_cycles({path, "_busy_cycles"}, ddr_path ? ddr_busy_cycles : dma_busy_cycles, 0);
      check_cycles({path, "_exec_cycles"}, ddr_path ? ddr_exec_cycles : dma_exec_cycles, 0);
      @(negedge user_clk);
      check_flags({path, "_start"}, ddr_path ? 8'(ddr_start) : 8'(dma_start), 8'd0);
      repeat (gap) @(negedge user_clk);
      if (ddr_path) begin
         ddr_done_valid  = done_vec;
         ddr_done_cycles = counts;
      end else begin
         dma_done_valid  = 1'b1;
         dma_done_cycles = counts[0];
      end
      @(negedge user_clk);
      dma_done_valid = 1'b0;
      ddr_done_valid = '0;
      // edges from acceptance to done, both ends counted once
      check_cycles({path, "_busy_cycles"}, ddr_path ? ddr_busy_cycles : dma_busy_cycles, gap + 2);
      check_cycles({path, "_exec_cycles"}, ddr_path ? ddr_exec_cycles : dma_exec_cycles,
                   counts[winner]);
      check_flags({path, "_running"}, 8'(ddr_path ? ddr_running : dma_running), 8'd0);
   endtask

   // expected stream statistics, inputs are stable at the rising edge
   always @(posedge user_clk) begin
      if (!user_aresetn) begin
         exp_rx_bytes = '0;
         exp_tx_bytes = '0;
         exp_packets  = '0;
         exp_meta     = '0;
         exp_status   = '0;
         exp_good     = '0;
      end else begin
         if (rx_beat.valid && rx_beat.ready)
            exp_rx_bytes += `STAT_BYTES_W'(keep_bytes_ref(rx_beat.keep));
         if (tx_beat.valid && tx_beat.ready) begin
            exp_tx_bytes += `STAT_BYTES_W'(keep_bytes_ref(tx_beat.keep));
            exp_packets  += `STAT_CNT_W'(tx_beat.last);
         end
         if (tx_meta_valid && tx_meta_ready)
            exp_meta += 1;
         if (tx_status_valid && tx_status_ready) begin
            exp_status += 1;
            exp_good   += `STAT_CNT_W'(status_good_ref(tx_status));
         end
      end
   end

   always @(negedge user_clk) begin
      if (stats_armed) begin
         check_bytes("rx_bytes", rx_bytes, exp_rx_bytes);
         check_bytes("tx_bytes", tx_bytes, exp_tx_bytes);
         check_count("tx_packets", tx_packets, exp_packets);
         check_count("tx_meta_count", tx_meta_count, exp_meta);
         check_count("tx_status_count", tx_status_count, exp_status);
         check_count("tx_status_good_count", tx_status_good_count, exp_good);
      end
   end

   initial begin
      logic [31:0] r;
      user_aresetn    = 1'b0;
      dma_cmd_valid   = 1'b0;
      ddr_cmd_valid   = 1'b0;
      dma_cmd         = '0;
      ddr_cmd         = '0;
      ddr_cmd_dest    = '0;
      dma_done_valid  = 1'b0;
      dma_done_cycles = '0;
      ddr_done_valid  = '0;
      ddr_done_cycles = '0;
      rx_beat         = '0;
      tx_beat         = '0;
      tx_meta_valid   = 1'b0;
      tx_meta_ready   = 1'b0;
      tx_status_valid = 1'b0;
      tx_status_ready = 1'b0;
      tx_status       = '0;
      repeat (5) @(posedge user_clk);
      @(negedge user_clk);
      user_aresetn = 1'b1;
      stats_armed  = 1'b1;
      @(negedge user_clk);   // first cycle out of reset
      check_flags("dma_cmd_ready", 8'(dma_cmd_ready), 8'd1);
      check_flags("ddr_cmd_ready", 8'(ddr_cmd_ready), 8'd1);
      check_flags("starts", {5'd0, ddr_start, dma_start}, 8'd0);
      check_flags("running", {6'd0, ddr_running, dma_running}, 8'd0);
      check_cycles("dma_busy_cycles", dma_busy_cycles, 0);
      check_cycles("dma_exec_cycles", dma_exec_cycles, 0);
      check_cycles("ddr_busy_cycles", ddr_busy_cycles, 0);
      check_cycles("ddr_exec_cycles", ddr_exec_cycles, 0);
      repeat (4) run_command(1'b0, 0, 1'b0);
      for (int dest = 0; dest < 4; dest++) begin
         run_command(1'b1, dest, 1'b0);
      end
      run_command(1'b1, 0, 1'b1);   // both ddr engines finish together
      repeat (STREAM_BEATS) begin
         r               = next_random();
         rx_beat         = random_beat();
         tx_beat         = random_beat();
         tx_meta_valid   = r[0];
         tx_meta_ready   = r[1] | r[2];
         tx_status_valid = r[3];
         tx_status_ready = r[4] | r[5];
         tx_status       = tx_status_t'({next_random(), next_random()});
         @(negedge user_clk);
      end
      rx_beat         = '0;
      tx_beat         = '0;
      tx_meta_valid   = 1'b0;
      tx_status_valid = 1'b0;
      repeat (2) @(negedge user_clk);
      @(posedge user_clk);   // away from the checking edge
      report_and_finish();
   end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+.
bench_pkg.sv
bench_cmd_decoder.sv
bench_run_timer.sv
stream_byte_counter.sv
tx_session_stats.sv
benchmark_role.sv
tb_benchmark_role.sv

// File: Makefile
# Verilator build and run for the benchmark role testbench
# override any variable on the command line, e.g. make run LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_benchmark_role
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Verification passed
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides, a missing pass line fails the target
run: compile
	./$(SIM) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
